//--- source/mem_map_pkg.sv
//**********************************************************
// Memory map package: address map, boot regions, tohost
// commands and the enum types shared by the interconnect
//**********************************************************
`default_nettype none

package mem_map_pkg;

    // Processor word and DRAM line widths
    localparam int addr_w = 32;
    localparam int line_w = 128;

    // Device field, address bits 31:28
    typedef enum logic [3:0] {
        dev_dram_low = 4'h0,
        dev_virtio   = 4'h4,
        dev_plic     = 4'h5,
        dev_clint    = 4'h6,
        dev_dram     = 4'h8
    } dev_t;

    // Framebuffer slot in the virtio window, bits 27:24
    localparam logic [3:0] virt_fb = 4'h5;

    localparam logic [addr_w-1:0] offset_mask = 32'h07ff_ffff;
    localparam logic [addr_w-1:0] tohost_addr = 32'h4000_1000;

    // Upper half of a tohost word, anything unlisted is idle
    typedef enum logic [15:0] {
        cmd_idle       = 16'h0000,
        cmd_print_char = 16'h0101,
        cmd_power_off  = 16'h0002
    } host_cmd_t;

    // Load and store widths
    typedef enum logic [2:0] {
        f3_lb  = 3'd0,
        f3_lh  = 3'd1,
        f3_lw  = 3'd2,
        f3_lbu = 3'd4,
        f3_lhu = 3'd5
    } funct3_t;
    localparam funct3_t f3_sw = f3_lw;

    // Boot regions in DRAM, in bytes
    localparam logic [addr_w-1:0] boot_image_bytes = 32'd32;
    localparam logic [addr_w-1:0] dtb_start        = 32'h0000_0100;
    localparam logic [addr_w-1:0] dtb_bytes        = 32'd16;

    typedef enum logic [1:0] {
        init_boot_image,
        init_dtb,
        init_done_st
    } init_state_t;

endpackage

`default_nettype wire

//--- source/boot_loader_ctrl.sv
//**********************************************************
// Boot loader sequencer: writes the loader stream into the
// boot image and device tree regions, keeps a checksum
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module boot_loader_ctrl (
    input  wire                             CLK,
    input  wire                             rst,
    input  wire                             loader_we,
    input  wire  [mem_map_pkg::addr_w-1:0]  loader_data,
    output logic                            boot_we,
    output logic [mem_map_pkg::addr_w-1:0]  boot_addr,
    output logic                            init_done,
    output logic [mem_map_pkg::addr_w-1:0]  checksum
);

    mem_map_pkg::init_state_t        state;
    logic [mem_map_pkg::addr_w-1:0]  load_addr;
    logic                            last_image_word;
    logic                            last_dtb_word;

    // Last word of each region
    assign last_image_word = load_addr == mem_map_pkg::boot_image_bytes - 4;
    assign last_dtb_word   = load_addr == mem_map_pkg::dtb_start + mem_map_pkg::dtb_bytes - 4;

    // Loader strobes are ignored once both regions are full
    assign boot_we   = loader_we && (state != mem_map_pkg::init_done_st);
    assign boot_addr = load_addr;
    assign init_done = state == mem_map_pkg::init_done_st;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state     <= mem_map_pkg::init_boot_image;
            load_addr <= '0;
        end else if (boot_we) begin
            case (state)
                mem_map_pkg::init_boot_image: begin
                    if (last_image_word) begin
                        load_addr <= mem_map_pkg::dtb_start;
                        state     <= mem_map_pkg::init_dtb;
                    end else begin
                        load_addr <= load_addr + 4;
                    end
                end
                mem_map_pkg::init_dtb: begin
                    load_addr <= load_addr + 4;
                    if (last_dtb_word) begin
                        state <= mem_map_pkg::init_done_st;
                    end
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

    // Running sum over every accepted word
    always_ff @(posedge CLK) begin
        if (rst) begin
            checksum <= '0;
        end else if (boot_we) begin
            checksum <= checksum + loader_data;
        end
    end

endmodule

`default_nettype wire

//--- source/device_router.sv
//**********************************************************
// Device router: decodes processor accesses into DRAM and
// device strobes, returns read data one cycle later
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module device_router (
    input  wire                             CLK,
    input  wire                             rst,
    input  wire  [mem_map_pkg::addr_w-1:0]  data_addr,
    input  wire                             data_we,
    input  wire                             data_re,
    input  wire                             init_done,
    input  wire                             dram_busy,
    input  wire  [mem_map_pkg::addr_w-1:0]  plic_rdata,
    input  wire  [mem_map_pkg::addr_w-1:0]  clint_rdata,
    input  wire  [mem_map_pkg::addr_w-1:0]  fb_rdata,
    input  wire  [mem_map_pkg::addr_w-1:0]  dram_word,
    output logic                            cpu_dram_we,
    output logic                            cpu_dram_rd,
    output logic                            plic_we,
    output logic                            plic_re,
    output logic                            clint_we,
    output logic                            fb_we,
    output logic [mem_map_pkg::addr_w-1:0]  data_rdata
);

    mem_map_pkg::dev_t  dev;
    logic [3:0]         virt;
    logic               is_dram;
    logic               wr_ok;
    logic               rd_ok;
    logic [3:0]         sel_dev;
    logic [3:0]         sel_virt;

    assign dev  = mem_map_pkg::dev_t'(data_addr[31:28]);
    assign virt = data_addr[27:24];

    assign is_dram = (dev == mem_map_pkg::dev_dram) || (dev == mem_map_pkg::dev_dram_low);

    // Nothing reaches a device until boot is over
    assign wr_ok = data_we && init_done;
    assign rd_ok = data_re && init_done;

    assign cpu_dram_we = wr_ok && is_dram && !dram_busy;
    assign cpu_dram_rd = rd_ok && is_dram && !dram_busy;
    assign plic_we     = wr_ok && (dev == mem_map_pkg::dev_plic);
    assign plic_re     = rd_ok && (dev == mem_map_pkg::dev_plic);
    assign clint_we    = wr_ok && (dev == mem_map_pkg::dev_clint);
    assign fb_we       = wr_ok && (dev == mem_map_pkg::dev_virtio) && (virt == mem_map_pkg::virt_fb);

    // Remember who was addressed, the reply comes next cycle
    always_ff @(posedge CLK) begin
        if (rst) begin
            sel_dev  <= 4'hf;
            sel_virt <= 4'h0;
        end else if (wr_ok || rd_ok) begin
            sel_dev  <= dev;
            sel_virt <= virt;
        end
    end

    always_comb begin
        case (sel_dev)
            mem_map_pkg::dev_plic:     data_rdata = plic_rdata;
            mem_map_pkg::dev_clint:    data_rdata = clint_rdata;
            mem_map_pkg::dev_dram,
            mem_map_pkg::dev_dram_low: data_rdata = dram_word;
            mem_map_pkg::dev_virtio: begin
                data_rdata = (sel_virt == mem_map_pkg::virt_fb) ? fb_rdata : '0;
            end
            default:                   data_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/load_aligner.sv
//**********************************************************
// Load aligner: picks the addressed bytes out of a DRAM
// line and sign or zero extends them to a word
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module load_aligner (
    input  wire                             CLK,
    input  wire                             rst,
    input  wire                             capture,
    input  wire  [3:0]                      offset,
    input  wire  mem_map_pkg::funct3_t      ctrl,
    input  wire  [mem_map_pkg::line_w-1:0]  dram_rdata128,
    output logic [mem_map_pkg::addr_w-1:0]  dram_word
);

    logic [3:0]                      r_offset;
    mem_map_pkg::funct3_t            r_ctrl;
    logic [mem_map_pkg::line_w-1:0]  shifted;
    logic [mem_map_pkg::addr_w-1:0]  raw;

    // Held until the line comes back
    always_ff @(posedge CLK) begin
        if (rst) begin
            r_offset <= 4'h0;
            r_ctrl   <= mem_map_pkg::f3_lw;
        end else if (capture) begin
            r_offset <= offset;
            r_ctrl   <= ctrl;
        end
    end

    // Byte offset to bit shift
    assign shifted = dram_rdata128 >> {r_offset, 3'b000};
    assign raw     = shifted[mem_map_pkg::addr_w-1:0];

    always_comb begin
        case (r_ctrl)
            mem_map_pkg::f3_lb:  dram_word = {{24{raw[7]}}, raw[7:0]};
            mem_map_pkg::f3_lh:  dram_word = {{16{raw[15]}}, raw[15:0]};
            mem_map_pkg::f3_lbu: dram_word = {24'h0, raw[7:0]};
            mem_map_pkg::f3_lhu: dram_word = {16'h0, raw[15:0]};
            default:             dram_word = raw;
        endcase
    end

endmodule

`default_nettype wire

//--- source/host_cmd_unit.sv
//**********************************************************
// Host command register: tohost writes print one character
// or power the system off
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module host_cmd_unit (
    input  wire                             CLK,
    input  wire                             rst,
    input  wire  [mem_map_pkg::addr_w-1:0]  data_addr,
    input  wire                             data_we,
    input  wire  [mem_map_pkg::addr_w-1:0]  data_wdata,
    output logic                            uart_we,
    output logic [7:0]                      uart_data,
    output logic                            finish
);

    logic [mem_map_pkg::addr_w-1:0]  tohost;
    mem_map_pkg::host_cmd_t          cmd;
    logic                            host_hit;

    assign host_hit = data_we && (data_addr == mem_map_pkg::tohost_addr);
    assign cmd      = mem_map_pkg::host_cmd_t'(tohost[31:16]);

    // A printed character clears the register, power off stays
    always_ff @(posedge CLK) begin
        if (rst) begin
            tohost <= '0;
        end else if (host_hit) begin
            tohost <= data_wdata;
        end else if (cmd == mem_map_pkg::cmd_print_char) begin
            tohost <= {mem_map_pkg::cmd_idle, 16'h0000};
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            uart_we <= 1'b0;
            finish  <= 1'b0;
        end else begin
            uart_we <= cmd == mem_map_pkg::cmd_print_char;
            // Sticky once set
            if (cmd == mem_map_pkg::cmd_power_off) begin
                finish <= 1'b1;
            end
        end
    end

    // Character byte, only meaningful with uart_we
    always_ff @(posedge CLK) begin
        if (cmd == mem_map_pkg::cmd_print_char) begin
            uart_data <= tohost[7:0];
        end
    end

endmodule

`default_nettype wire

//--- source/mem_interconnect.sv
//**********************************************************
// Memory interconnect top: shares the DRAM port between
// boot loader and processor, routes device accesses
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module mem_interconnect (
    input  wire                             CLK,
    input  wire                             rst,
    input  wire                             loader_we,
    input  wire  [mem_map_pkg::addr_w-1:0]  loader_data,
    input  wire  [mem_map_pkg::addr_w-1:0]  data_addr,
    input  wire  [mem_map_pkg::addr_w-1:0]  data_wdata,
    input  wire                             data_we,
    input  wire                             data_re,
    input  wire  mem_map_pkg::funct3_t      data_ctrl,
    input  wire                             dram_busy,
    input  wire  [mem_map_pkg::line_w-1:0]  dram_rdata128,
    input  wire  [mem_map_pkg::addr_w-1:0]  plic_rdata,
    input  wire  [mem_map_pkg::addr_w-1:0]  clint_rdata,
    input  wire  [mem_map_pkg::addr_w-1:0]  fb_rdata,
    output logic                            dram_rd_en,
    output logic                            dram_wr_en,
    output logic [mem_map_pkg::addr_w-1:0]  dram_addr,
    output logic [mem_map_pkg::addr_w-1:0]  dram_wdata,
    output mem_map_pkg::funct3_t            dram_ctrl,
    output logic                            plic_we,
    output logic                            plic_re,
    output logic                            clint_we,
    output logic                            fb_we,
    output logic [mem_map_pkg::addr_w-1:0]  wr_data,
    output logic [mem_map_pkg::addr_w-1:0]  data_rdata,
    output logic                            proc_busy,
    output logic                            init_done,
    output logic [mem_map_pkg::addr_w-1:0]  checksum,
    output logic                            uart_we,
    output logic [7:0]                      uart_data,
    output logic                            finish
);

    logic                            boot_we;
    logic [mem_map_pkg::addr_w-1:0]  boot_addr;
    logic                            cpu_dram_we;
    logic                            cpu_dram_rd;
    logic [mem_map_pkg::addr_w-1:0]  dram_word;
    logic                            host_we;

    boot_loader_ctrl i_boot_loader_ctrl (
        .CLK         (CLK),
        .rst         (rst),
        .loader_we   (loader_we),
        .loader_data (loader_data),
        .boot_we     (boot_we),
        .boot_addr   (boot_addr),
        .init_done   (init_done),
        .checksum    (checksum)
    );

    // Loader owns DRAM until boot completes
    assign dram_wr_en = init_done ? cpu_dram_we : boot_we;
    assign dram_rd_en = cpu_dram_rd;
    assign dram_addr  = init_done ? (data_addr & mem_map_pkg::offset_mask) : boot_addr;
    assign dram_wdata = init_done ? data_wdata : loader_data;
    assign dram_ctrl  = init_done ? data_ctrl : mem_map_pkg::f3_sw;

    assign wr_data   = data_wdata;
    assign proc_busy = !init_done || dram_busy;

    device_router i_device_router (
        .CLK         (CLK),
        .rst         (rst),
        .data_addr   (data_addr),
        .data_we     (data_we),
        .data_re     (data_re),
        .init_done   (init_done),
        .dram_busy   (dram_busy),
        .plic_rdata  (plic_rdata),
        .clint_rdata (clint_rdata),
        .fb_rdata    (fb_rdata),
        .dram_word   (dram_word),
        .cpu_dram_we (cpu_dram_we),
        .cpu_dram_rd (cpu_dram_rd),
        .plic_we     (plic_we),
        .plic_re     (plic_re),
        .clint_we    (clint_we),
        .fb_we       (fb_we),
        .data_rdata  (data_rdata)
    );

    load_aligner i_load_aligner (
        .CLK           (CLK),
        .rst           (rst),
        .capture       (dram_rd_en),
        .offset        (dram_addr[3:0]),
        .ctrl          (data_ctrl),
        .dram_rdata128 (dram_rdata128),
        .dram_word     (dram_word)
    );

    // tohost is a processor access as well
    assign host_we = data_we && init_done;

    host_cmd_unit i_host_cmd_unit (
        .CLK        (CLK),
        .rst        (rst),
        .data_addr  (data_addr),
        .data_we    (host_we),
        .data_wdata (data_wdata),
        .uart_we    (uart_we),
        .uart_data  (uart_data),
        .finish     (finish)
    );

endmodule

`default_nettype wire

//--- testbench/mem_interconnect_checker.sv
//**********************************************************
// Interconnect checker: concurrent assertions on the top
// level ports, bound into mem_interconnect
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module mem_interconnect_checker (
    input wire CLK,
    input wire rst,
    input wire init_done,
    input wire dram_rd_en,
    input wire dram_wr_en,
    input wire plic_we,
    input wire plic_re,
    input wire clint_we,
    input wire fb_we,
    input wire uart_we,
    input wire finish
);

    // One character per command
    a_uart_single: assert property (@(posedge CLK) disable iff (rst) uart_we |=> !uart_we)
        else $error("uart_we was high for two cycles in a row");

    a_finish_sticky: assert property (@(posedge CLK) disable iff (rst) finish |=> finish)
        else $error("finish fell after it was set");

    // Devices stay quiet while the loader owns the system
    a_no_early_strobe: assert property (@(posedge CLK) disable iff (rst)
        !init_done |-> !(plic_we || plic_re || clint_we || fb_we || dram_rd_en))
        else $error("processor side strobe before init_done");

    a_dram_one_dir: assert property (@(posedge CLK) disable iff (rst)
        !(dram_rd_en && dram_wr_en))
        else $error("dram_rd_en and dram_wr_en high together");

endmodule

bind mem_interconnect mem_interconnect_checker i_checker (
    .CLK        (CLK),
    .rst        (rst),
    .init_done  (init_done),
    .dram_rd_en (dram_rd_en),
    .dram_wr_en (dram_wr_en),
    .plic_we    (plic_we),
    .plic_re    (plic_re),
    .clint_we   (clint_we),
    .fb_we      (fb_we),
    .uart_we    (uart_we),
    .finish     (finish)
);

`default_nettype wire

//--- testbench/tb_mem_interconnect.sv
//**********************************************************
// Memory interconnect testbench: DRAM and device models,
// stimulus and expected results from the input file
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module tb_mem_interconnect;

    localparam int max_records = 64;

    logic                  CLK;
    logic                  rst;
    logic                  loader_we;
    logic [31:0]           loader_data;
    logic [31:0]           data_addr;
    logic [31:0]           data_wdata;
    logic                  data_we;
    logic                  data_re;
    mem_map_pkg::funct3_t  data_ctrl;
    logic                  dram_busy;
    logic [127:0]          dram_rdata128;
    logic [31:0]           plic_rdata;
    logic [31:0]           clint_rdata;
    logic [31:0]           fb_rdata;
    logic                  dram_rd_en;
    logic                  dram_wr_en;
    logic [31:0]           dram_addr;
    logic [31:0]           dram_wdata;
    mem_map_pkg::funct3_t  dram_ctrl;
    logic                  plic_we;
    logic                  plic_re;
    logic                  clint_we;
    logic                  fb_we;
    logic [31:0]           wr_data;
    logic [31:0]           data_rdata;
    logic                  proc_busy;
    logic                  init_done;
    logic [31:0]           checksum;
    logic                  uart_we;
    logic [7:0]            uart_data;
    logic                  finish;

    logic [31:0]   records [0:5*max_records-1];
    logic [127:0]  dram_mem [0:255];
    logic [31:0]   boot_words [0:15];
    logic [31:0]   boot_sum = '0;
    logic          powered_off = 1'b0;
    int            num_records = 0;
    int            boot_count = 0;
    int            error_count = 0;
    int            check_count = 0;
    int            cycle_count = 0;
    int            cycle_limit = 100000;

    mem_interconnect i_dut (.*);

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    // Run limit counted in clock cycles
    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles with %0d errors so far",
                     cycle_limit, error_count);
            $display("Finished with errors");
            $finish;
        end
    end

    // Stores merge bytes into the line and loads return it one cycle later
    function automatic logic [127:0] merge_store(input logic [127:0] line, input logic [3:0] off,
                                                 input logic [31:0] wdata,
                                                 input mem_map_pkg::funct3_t ctrl);
        logic [127:0] result;
        int           nbytes;
        int           i;
        result = line;
        nbytes = (ctrl == mem_map_pkg::f3_lb) ? 1 : (ctrl == mem_map_pkg::f3_lh) ? 2 : 4;
        for (i = 0; i < nbytes; i++) begin
            result[(off + i) * 8 +: 8] = wdata[i * 8 +: 8];
        end
        return result;
    endfunction

    always @(posedge CLK) begin
        if (dram_wr_en) begin
            dram_mem[dram_addr[11:4]] <= merge_store(dram_mem[dram_addr[11:4]], dram_addr[3:0],
                                                     dram_wdata, dram_ctrl);
        end
        if (dram_rd_en) begin
            dram_rdata128 <= dram_mem[dram_addr[11:4]];
        end
    end

    // Image words come before the device tree region
    function automatic logic [31:0] boot_offset(input int n);
        if (n < 8) begin
            return n * 4;
        end
        return mem_map_pkg::dtb_start + (n - 8) * 4;
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_strobe(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_ctrl(input mem_map_pkg::funct3_t got, input mem_map_pkg::funct3_t exp,
                              input string what);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    // Mask bits from bit 0 up are dram_wr_en, dram_rd_en, plic_we, plic_re, clint_we, fb_we
    task automatic check_strobes(input logic [5:0] mask, input string what);
        check_strobe(dram_wr_en, mask[0], {what, ": dram_wr_en"});
        check_strobe(dram_rd_en, mask[1], {what, ": dram_rd_en"});
        check_strobe(plic_we, mask[2], {what, ": plic_we"});
        check_strobe(plic_re, mask[3], {what, ": plic_re"});
        check_strobe(clint_we, mask[4], {what, ": clint_we"});
        check_strobe(fb_we, mask[5], {what, ": fb_we"});
    endtask

    // DRAM busy wanders until the processor side is free
    task automatic wait_ready();
        do begin
            @(posedge CLK);
            dram_busy <= ($urandom % 4) == 0;
            @(negedge CLK);
            check_strobe(proc_busy, dram_busy || boot_count < 12, "proc_busy against dram_busy");
        end while (proc_busy);
    endtask

    task automatic load_word(input logic [31:0] word);
        logic [31:0] exp_addr;
        exp_addr = boot_offset(boot_count);
        @(posedge CLK);
        loader_we   <= 1'b1;
        loader_data <= word;
        @(negedge CLK);
        check_strobe(dram_wr_en, 1'b1, "boot dram_wr_en");
        check_word(dram_addr, exp_addr, "boot dram_addr");
        check_word(dram_wdata, word, "boot dram_wdata");
        check_ctrl(dram_ctrl, mem_map_pkg::f3_sw, "boot dram_ctrl");
        check_strobe(init_done, 1'b0, "init_done during the loader strobe");
        boot_words[boot_count[3:0]] = word;
        boot_sum = boot_sum + word;
        boot_count++;
        @(posedge CLK);
        loader_we <= 1'b0;
        @(negedge CLK);
        check_strobe(init_done, boot_count >= 12, "init_done after the loader strobe");
        check_strobe(proc_busy, boot_count < 12, "proc_busy after the loader strobe");
        @(posedge CLK);
    endtask

    task automatic check_boot();
        logic [127:0] line;
        logic [31:0]  addr;
        int           i;
        @(negedge CLK);
        check_strobe(init_done, 1'b1, "init_done after boot");
        check_word(checksum, boot_sum, "boot checksum");
        for (i = 0; i < 12; i++) begin
            addr = boot_offset(i);
            line = dram_mem[addr[11:4]] >> (addr[3:0] * 8);
            check_word(line[31:0], boot_words[i], $sformatf("boot word at offset %h", addr));
        end
    endtask

    // Early accesses go out during boot with both strobes and no wait
    task automatic proc_write(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [31:0] ctrl, input logic [31:0] mask,
                              input logic early);
        if (!early) begin
            wait_ready();
        end
        @(posedge CLK);
        data_addr  <= addr;
        data_wdata <= wdata;
        data_ctrl  <= mem_map_pkg::funct3_t'(ctrl[2:0]);
        data_we    <= 1'b1;
        data_re    <= early;
        @(negedge CLK);
        check_strobes(mask[5:0], $sformatf("access to %h", addr));
        check_word(wr_data, wdata, "wr_data");
        if (mask[0]) begin
            check_word(dram_addr, {5'b0, addr[26:0]}, "masked dram_addr");
            check_word(dram_wdata, wdata, "dram_wdata");
            check_ctrl(dram_ctrl, mem_map_pkg::funct3_t'(ctrl[2:0]), "dram_ctrl");
        end
        @(posedge CLK);
        data_we <= 1'b0;
        data_re <= 1'b0;
    endtask

    task automatic proc_read(input logic [31:0] addr, input logic [31:0] ctrl,
                             input logic [31:0] exp_val);
        wait_ready();
        @(posedge CLK);
        data_addr <= addr;
        data_ctrl <= mem_map_pkg::funct3_t'(ctrl[2:0]);
        data_re   <= 1'b1;
        @(negedge CLK);
        check_strobe(plic_re, addr[31:28] == 4'h5, "plic_re on read");
        @(posedge CLK);
        data_re <= 1'b0;
        @(negedge CLK);
        check_word(data_rdata, exp_val, $sformatf("read data from %h", addr));
    endtask

    // Expect bit 8 marks a character and bit 9 a power off
    task automatic host_write(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [31:0] exp_val);
        wait_ready();
        @(posedge CLK);
        data_addr  <= addr;
        data_wdata <= wdata;
        data_we    <= 1'b1;
        @(posedge CLK);
        data_we <= 1'b0;
        @(negedge CLK);
        check_strobe(uart_we, 1'b0, "uart_we one cycle after the tohost write");
        check_strobe(finish, powered_off, "finish one cycle after the tohost write");
        @(negedge CLK);
        check_strobe(uart_we, exp_val[8], "uart_we two cycles after the tohost write");
        if (exp_val[8]) begin
            check_byte(uart_data, exp_val[7:0], "uart_data");
        end
        powered_off = powered_off || exp_val[9];
        check_strobe(finish, powered_off, "finish two cycles after the tohost write");
        @(negedge CLK);
        check_strobe(uart_we, 1'b0, "uart_we three cycles after the tohost write");
    endtask

    initial begin
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] ctrl;
        logic [31:0] exp_val;
        int          i;
        void'($urandom(90));
        rst           = 1'b1;
        loader_we     = 1'b0;
        loader_data   = '0;
        data_addr     = '0;
        data_wdata    = '0;
        data_we       = 1'b0;
        data_re       = 1'b0;
        data_ctrl     = mem_map_pkg::f3_lw;
        dram_busy     = 1'b0;
        dram_rdata128 = '0;
        plic_rdata    = 32'hA5A5_0005;
        clint_rdata   = 32'hA5A5_0006;
        fb_rdata      = 32'hA5A5_00FB;
        for (i = 0; i < 5 * max_records; i++) begin
            records[i] = '0;
        end
        for (i = 0; i < 256; i++) begin
            dram_mem[i] = '0;
        end
        $readmemh("testbench/mem_interconnect_input.txt", records);
        while (num_records < max_records && records[5 * num_records] != 0) begin
            num_records++;
        end
        cycle_limit = 8 + 12 * num_records + 50;

        repeat (8) @(posedge CLK);
        rst <= 1'b0;
        @(negedge CLK);
        check_strobes(6'b0, "after reset");
        check_strobe(uart_we, 1'b0, "uart_we after reset");
        check_strobe(finish, 1'b0, "finish after reset");
        check_strobe(init_done, 1'b0, "init_done after reset");

        for (i = 0; i < num_records; i++) begin
            kind    = records[5 * i];
            addr    = records[5 * i + 1];
            wdata   = records[5 * i + 2];
            ctrl    = records[5 * i + 3];
            exp_val = records[5 * i + 4];
            case (kind)
                1: load_word(wdata);
                2: proc_write(addr, wdata, ctrl, exp_val, 1'b0);
                3: proc_read(addr, ctrl, exp_val);
                4: host_write(addr, wdata, exp_val);
                5: proc_write(addr, wdata, ctrl, exp_val, 1'b1);
                6: check_boot();
                default: begin
                    $display("Record %0d of the input file has an unknown kind %h", i, kind);
                    error_count++;
                end
            endcase
        end

        // Power off is sticky
        repeat (3) @(negedge CLK);
        check_strobe(finish, powered_off, "finish at the end of the run");

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/mem_interconnect_input.txt
// Columns: kind addr data ctrl expect, kinds 1 loader word, 2 write, 3 read, 4 tohost,
// 5 access during boot, 6 boot check; expect is a strobe mask, read data or host result
1 00000000 00000297 0 00000000
1 00000000 02028593 0 00000000
1 00000000 F1402573 0 00000000
1 00000000 0182A283 0 00000000
1 00000000 00028067 0 00000000
5 50000000 11111111 2 00000000
5 80000300 22222222 2 00000000
1 00000000 00000000 0 00000000
1 00000000 87E00000 0 00000000
1 00000000 00000013 0 00000000
1 00000000 D00DFEED 0 00000000
1 00000000 00000038 0 00000000
1 00000000 00000011 0 00000000
1 00000000 00000028 0 00000000
6 00000000 00000000 0 00000000
2 80000200 876543F1 2 00000001
2 80000204 12345678 2 00000001
2 00000210 CAFEF00D 2 00000001
2 50000004 0000BEEF 2 00000004
2 60004000 00C0FFEE 2 00000010
2 45000010 00FF00FF 2 00000020
2 30000000 DEADBEEF 2 00000000
3 80000200 00000000 0 FFFFFFF1
3 80000201 00000000 4 00000043
3 80000202 00000000 1 FFFF8765
3 80000202 00000000 5 00008765
3 80000200 00000000 2 876543F1
3 80000207 00000000 0 00000012
3 80000206 00000000 1 00001234
3 80000205 00000000 4 00000056
3 00000210 00000000 2 CAFEF00D
3 80000212 00000000 1 FFFFCAFE
3 80000100 00000000 2 D00DFEED
3 00000008 00000000 2 F1402573
3 50000000 00000000 2 A5A50005
3 60000008 00000000 2 A5A50006
3 45000000 00000000 2 A5A500FB
3 30000000 00000000 2 00000000
3 41000000 00000000 2 00000000
4 40001000 01010048 2 00000148
4 40001000 01010069 2 00000169
4 40001000 00020000 2 00000200

//--- all.f
source/mem_map_pkg.sv
source/boot_loader_ctrl.sv
source/device_router.sv
source/load_aligner.sv
source/host_cmd_unit.sv
source/mem_interconnect.sv
testbench/mem_interconnect_checker.sv
testbench/tb_mem_interconnect.sv

//--- Bender.yml
package:
  name: mem_interconnect

sources:
  - files:
      - source/mem_map_pkg.sv
      - source/boot_loader_ctrl.sv
      - source/device_router.sv
      - source/load_aligner.sv
      - source/host_cmd_unit.sv
      - source/mem_interconnect.sv
  - target: test
    files:
      - testbench/mem_interconnect_checker.sv
      - testbench/tb_mem_interconnect.sv
